//--- src.f
verilog/fas_pkg.sv
verilog/fir_filter.sv
verilog/frame_assembler.sv
verilog/peak_locator.sv
verilog/fas_top.sv
verification/fas_chk.sv
verification/fas_tb.sv

//--- Makefile
TOP = fas_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- verification/fas_tb.sv
// Frequency analysis chain testbench
`timescale 1ns/100ps
`default_nettype none

module fas_tb import fas_pkg::*; ();

  localparam int RESET_CYCLES   = 8;
  localparam int RUN_CYCLES     = 1500;
  localparam int TIMEOUT_CYCLES = RUN_CYCLES + 500;  // Run length plus reset and slack
  localparam int FRAME_DELAY    = 6;                 // Last capture, strobe, five steps

  logic               clk;
  logic               rst;
  logic               data_valid;
  sample_t            data;
  logic               fir_valid;
  sample_t            fir_d;
  logic               done;
  logic [INDEX_W-1:0] peak_index;

  integer seed;
  int     cycle_count;

  // Reference model state
  int                 m_taps [NUM_TAPS];             // m_taps[0] is the newest sample
  longint             m_acc;
  int                 m_run;                         // Consecutive valid edges
  logic               m_started;                     // Framer has begun capturing
  int                 frame_buf [FRAME_LEN];
  int                 frame_fill;
  int                 due_q [$];                     // Cycle of each expected done
  int                 idx_q [$];                     // Expected index at that done
  logic [INDEX_W-1:0] m_index;
  int                 done_count;

  fas_top dut (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fir_valid  (fir_valid),
    .fir_d      (fir_d),
    .done       (done),
    .peak_index (peak_index)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////
  // Model helpers
  ////////////////////
  // Sign bit, integer bits 30..16, plus one when negative
  function automatic sample_t round_acc(longint acc);
    logic [ACC_W-1:0] a;
    a = acc[ACC_W-1:0];
    return sample_t'({a[ACC_W-1], a[30:16]} + {15'd0, a[ACC_W-1]});
  endfunction

  function automatic int frame_argmax(input int s [FRAME_LEN]);
    longint best;
    int     best_i;
    best   = -1;
    best_i = 0;
    for (int i = 0; i < FRAME_LEN; i++) begin
      if (longint'(s[i]) * longint'(s[i]) >= best) begin  // Later index wins a tie
        best   = longint'(s[i]) * longint'(s[i]);
        best_i = i;
      end
    end
    return best_i;
  endfunction

  function automatic logic valid_at(int t);
    return !((t >= 20 && t < 23) || (t >= 95 && t < 98) || (t == 140) ||
             (t >= 400 && t < 405) || (t >= 900 && t < 902));
  endfunction

  task automatic check_equal(string what, longint got, longint exp);
    assert (got == exp) else begin
      $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  task automatic drive_inputs(int t);
    data_valid = valid_at(t);
    if (t >= 600 && t < 680) begin
      data = ($random(seed) & 1) ? sample_t'(16'h7FFF) : sample_t'(16'h8000);  // Full scale
    end else if (t >= 1000 && t < 1080) begin
      data = sample_t'(16'h1234);                    // Flat input gives equal energies
    end else begin
      data = sample_t'($random(seed));
    end
  endtask

  // Filter update for the inputs seen at this edge
  task automatic model_step();
    if (data_valid) begin
      m_acc = 0;
      for (int k = 0; k < NUM_TAPS; k++) begin
        m_acc = m_acc + longint'(m_taps[k]) * longint'(FIR_COEF[k]);
      end
      for (int k = NUM_TAPS - 1; k > 0; k--) begin
        m_taps[k] = m_taps[k-1];
      end
      m_taps[0] = int'(data);
      if (m_run < FIR_START_COUNT) begin
        m_run++;
      end
    end else begin
      m_acc = 0;
      m_run = 0;
    end
  endtask

  task automatic check_cycle(int t);
    sample_t exp_d;
    exp_d = round_acc(m_acc);
    check_equal("fir_valid", fir_valid, m_run == FIR_START_COUNT);
    check_equal("fir_d", fir_d, exp_d);
    if (due_q.size() > 0 && due_q[0] == t) begin
      check_equal("done", done, 1);
      check_equal("peak_index", peak_index, idx_q[0]);
      m_index = INDEX_W'(idx_q[0]);
      void'(due_q.pop_front());
      void'(idx_q.pop_front());
      done_count++;
    end else begin
      check_equal("done", done, 0);
      check_equal("peak_index", peak_index, m_index);  // Holds between pulses
    end
    if (m_run == FIR_START_COUNT) begin
      m_started = 1'b1;
    end
    if (m_started) begin
      frame_buf[frame_fill] = int'(exp_d);           // Captured at the next edge
      frame_fill++;
      if (frame_fill == FRAME_LEN) begin
        due_q.push_back(t + FRAME_DELAY);
        idx_q.push_back(frame_argmax(frame_buf));
        frame_fill = 0;
      end
    end
  endtask

  ////////////////////
  // Timeout
  ////////////////////
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation finished: FAIL");
    $fatal(1, "Timeout");
  end

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    seed       = 32'h299f16c6;
    rst        = 1'b1;
    data_valid = 1'b0;
    data       = '0;
    m_acc      = 0;
    m_run      = 0;
    m_started  = 1'b0;
    frame_fill = 0;
    m_index    = '0;
    done_count = 0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      m_taps[k] = 0;
    end

    repeat (RESET_CYCLES) begin
      @(posedge clk);
      #1;
      check_equal("fir_valid in reset", fir_valid, 0);
      check_equal("done in reset", done, 0);
      check_equal("fir_d in reset", fir_d, 0);
      check_equal("peak_index in reset", peak_index, 0);
    end
    rst = 1'b0;
    drive_inputs(0);

    for (int t = 0; t < RUN_CYCLES; t++) begin
      @(posedge clk);
      model_step();
      #1;
      check_cycle(t);
      drive_inputs(t + 1);
    end

    if (done_count > 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("No done pulse was seen during the run");
      $display("Simulation finished: FAIL");
      $fatal(1, "No frames checked");
    end
  end

endmodule

`default_nettype wire

//--- verification/fas_chk.sv
// Chain timing assertions
`timescale 1ns/100ps
`default_nettype none

module fas_chk import fas_pkg::*; (
  input wire clk,
  input wire rst,
  input wire data_valid,
  input wire fir_valid,
  input wire frame_valid,
  input wire done
);

  ////////////////////
  // Strobe timing
  ////////////////////
  a_frame_to_done: assert property (
    @(posedge clk) disable iff (rst) frame_valid |-> ##5 done
  ) else $error("done did not follow frame_valid five cycles later");

  a_done_single: assert property (
    @(posedge clk) disable iff (rst) done |=> !done
  ) else $error("done stayed high for two cycles");

  // Filter output needs a valid sample at the edge before
  a_fir_valid_src: assert property (
    @(posedge clk) disable iff (rst) fir_valid |-> $past(data_valid)
  ) else $error("fir_valid high without data_valid at the previous edge");

endmodule

bind fas_top fas_chk u_chk (
  .clk         (clk),
  .rst         (rst),
  .data_valid  (data_valid),
  .fir_valid   (fir_valid),
  .frame_valid (frame_valid),
  .done        (done)
);

`default_nettype wire

//--- verilog/fas_top.sv
// Frequency analysis chain top
`timescale 1ns/100ps
`default_nettype none

module fas_top import fas_pkg::*; (
  input  wire                clk,
  input  wire                rst,
  input  wire                data_valid,
  input  wire sample_t       data,
  output logic               fir_valid,
  output sample_t            fir_d,
  output logic               done,
  output logic [INDEX_W-1:0] peak_index
);

  logic   frame_valid;                           // One-cycle strobe per frame
  frame_t frame;

  fir_filter u_fir (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fir_valid  (fir_valid),
    .fir_d      (fir_d)
  );

  frame_assembler u_frame (
    .clk         (clk),
    .rst         (rst),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

  peak_locator u_peak (
    .clk         (clk),
    .rst         (rst),
    .frame_valid (frame_valid),
    .frame       (frame),
    .done        (done),
    .peak_index  (peak_index)
  );

endmodule

`default_nettype wire

//--- verilog/peak_locator.sv
// Frame energy peak search
`timescale 1ns/100ps
`default_nettype none

module peak_locator import fas_pkg::*; (
  input  wire                clk,
  input  wire                rst,
  input  wire                frame_valid,
  input  wire frame_t        frame,
  output logic               done,
  output logic [INDEX_W-1:0] peak_index
);

  localparam int STEP_W    = 3;
  localparam int DONE_STEP = 5;                  // Squaring plus four compare levels

  logic [STEP_W-1:0] step;                       // Zero while idle

  peak_t lvl0 [FRAME_LEN];                       // Sample energies
  peak_t lvl1 [FRAME_LEN/2];
  peak_t lvl2 [FRAME_LEN/4];
  peak_t lvl3 [FRAME_LEN/8];
  peak_t final_pick;                             // Winner of the last compare

  // The odd candidate always carries the higher index and wins a tie
  function automatic peak_t pick(peak_t lo, peak_t hi);
    return (hi.energy >= lo.energy) ? hi : lo;
  endfunction

  ////////////////////
  // Step sequencing
  ////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      step <= '0;
    end else if (frame_valid) begin
      step <= STEP_W'(1);
    end else if (step == STEP_W'(DONE_STEP)) begin
      step <= '0;
    end else if (step != '0) begin
      step <= step + 1'b1;
    end
  end

  assign done = (step == STEP_W'(DONE_STEP));

  ////////////////////
  // Energies and compare tree
  ////////////////////
  always_ff @(posedge clk) begin
    if (frame_valid) begin
      for (int i = 0; i < FRAME_LEN; i++) begin
        lvl0[i].energy <= frame.samples[i] * frame.samples[i];
        lvl0[i].index  <= INDEX_W'(i);
      end
    end
    if (step == STEP_W'(1)) begin
      for (int i = 0; i < FRAME_LEN/2; i++) begin
        lvl1[i] <= pick(lvl0[2*i], lvl0[2*i+1]);
      end
    end
    if (step == STEP_W'(2)) begin
      for (int i = 0; i < FRAME_LEN/4; i++) begin
        lvl2[i] <= pick(lvl1[2*i], lvl1[2*i+1]);
      end
    end
    if (step == STEP_W'(3)) begin
      for (int i = 0; i < FRAME_LEN/8; i++) begin
        lvl3[i] <= pick(lvl2[2*i], lvl2[2*i+1]);
      end
    end
  end

  assign final_pick = pick(lvl3[0], lvl3[1]);

  // Final compare lands on the edge that raises done
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      peak_index <= '0;
    end else if (step == STEP_W'(DONE_STEP - 1)) begin
      peak_index <= final_pick.index;
    end
  end

endmodule

`default_nettype wire

//--- verilog/frame_assembler.sv
// Serial to parallel frame capture
`timescale 1ns/100ps
`default_nettype none

module frame_assembler import fas_pkg::*; (
  input  wire          clk,
  input  wire          rst,
  input  wire          fir_valid,
  input  wire sample_t fir_d,
  output logic         frame_valid,
  output frame_t       frame
);

  logic               running;                   // Set by the first filtered sample
  logic [INDEX_W-1:0] slot;                      // Next slot to be written
  logic               capture;

  assign capture = running | fir_valid;

  ////////////////////
  // Slot counter and frame strobe
  ////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      running     <= 1'b0;
      slot        <= '0;
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= capture && (slot == INDEX_W'(FRAME_LEN - 1));
      if (capture) begin
        running <= 1'b1;
        slot    <= slot + 1'b1;                  // Wraps into the next frame
      end
    end
  end

  // Sample storage
  always_ff @(posedge clk) begin
    if (capture) begin
      frame.samples[slot] <= fir_d;
    end
  end

endmodule

`default_nettype wire

//--- verilog/fir_filter.sv
// FIR low-pass stage
`timescale 1ns/100ps
`default_nettype none

module fir_filter import fas_pkg::*; (
  input  wire          clk,
  input  wire          rst,
  input  wire          data_valid,
  input  wire sample_t data,
  output logic         fir_valid,
  output sample_t      fir_d
);

  localparam int CNT_W  = $clog2(FIR_START_COUNT + 1);
  localparam int FRAC_W = 16;                    // Fraction bits of the coefficients

  sample_t                 taps [NUM_TAPS];      // taps[0] is the newest sample
  logic signed [ACC_W-1:0] mac_sum;
  logic signed [ACC_W-1:0] acc;
  logic [CNT_W-1:0]        run_cnt;              // Consecutive valid edges

  ////////////////////
  // Multiply-accumulate
  ////////////////////
  always_comb begin
    mac_sum = '0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      mac_sum = mac_sum + taps[k] * FIR_COEF[k];  // Signed, sign-extended to ACC_W
    end
  end

  ////////////////////
  // Delay line, accumulator and start counter
  ////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int k = 0; k < NUM_TAPS; k++) begin
        taps[k] <= '0;
      end
      acc     <= '0;
      run_cnt <= '0;
    end else if (data_valid) begin
      taps[0] <= data;
      for (int k = 1; k < NUM_TAPS; k++) begin
        taps[k] <= taps[k-1];
      end
      acc <= mac_sum;                            // Sum over the old contents
      if (run_cnt != CNT_W'(FIR_START_COUNT)) begin
        run_cnt <= run_cnt + 1'b1;               // Saturates at the start count
      end
    end else begin
      // A gap clears the sum and restarts the run, the taps hold
      acc     <= '0;
      run_cnt <= '0;
    end
  end

  assign fir_valid = (run_cnt == CNT_W'(FIR_START_COUNT));

  // Sign plus Q16 integer bits, bumped by one when negative
  assign fir_d = {acc[ACC_W-1], acc[FRAC_W+SAMPLE_W-2:FRAC_W]}
               + SAMPLE_W'(acc[ACC_W-1]);

endmodule

`default_nettype wire

//--- verilog/fas_pkg.sv
// Frequency analysis shared definitions
`default_nettype none

package fas_pkg;

  ////////////////////
  // Sample and filter widths
  ////////////////////
  localparam int SAMPLE_W        = 16;           // Input and filtered sample
  localparam int COEF_W          = 20;           // Signed Q16 coefficient
  localparam int NUM_TAPS        = 32;
  localparam int ACC_W           = 41;           // Holds 32 products of 16x20 bits
  localparam int FIR_START_COUNT = 34;           // Valid run before output is trusted

  // Symmetric low-pass set, tap 0 pairs with the newest sample
  localparam logic signed [COEF_W-1:0] FIR_COEF [NUM_TAPS] = '{
    20'hFFF9E, 20'hFFF86, 20'hFFFA7, 20'h0003B,
    20'h0014B, 20'h0024A, 20'h00222, 20'hFFFE4,
    20'hFFBC5, 20'hFF7CA, 20'hFF74E, 20'hFFD74,
    20'h00B1A, 20'h01DAC, 20'h02F9E, 20'h03AA9,
    20'h03AA9, 20'h02F9E, 20'h01DAC, 20'h00B1A,
    20'hFFD74, 20'hFF74E, 20'hFF7CA, 20'hFFBC5,
    20'hFFFE4, 20'h00222, 20'h0024A, 20'h0014B,
    20'h0003B, 20'hFFFA7, 20'hFFF86, 20'hFFF9E
  };

  ////////////////////
  // Frame and peak format
  ////////////////////
  localparam int FRAME_LEN = 16;
  localparam int INDEX_W   = 4;                  // Sample index within a frame
  localparam int ENERGY_W  = 32;                 // Unsigned sample squared

  typedef logic signed [SAMPLE_W-1:0] sample_t;

  typedef struct packed {
    sample_t [FRAME_LEN-1:0] samples;            // Slot 0 arrives first
  } frame_t;

  typedef struct packed {
    logic [ENERGY_W-1:0] energy;
    logic [INDEX_W-1:0]  index;
  } peak_t;

endpackage

`default_nettype wire
